//--- spu_decode_macros.svh
`ifndef SPU_DECODE_MACROS_SVH
`define SPU_DECODE_MACROS_SVH

`define INSTR_W		32
`define PC_W		8
`define REG_ADDR_W	7
`define NUM_REGS	128
`define OP_W		11
`define IMM_W		18
`define UNIT_W		2
`define FMT_W		3
`define CNT_W		3	// wide enough for the longest window

`define UNIT_FP		2'd0	// even pipe
`define UNIT_FX2	2'd1
`define UNIT_BYTE	2'd2
`define UNIT_FX1	2'd3
`define UNIT_PERM	2'd0	// odd pipe
`define UNIT_LS		2'd1
`define UNIT_BR		2'd2

// cycles a destination stays in flight after issue
`define WIN_FP		5
`define WIN_LS		5
`define WIN_FX2		3
`define WIN_BYTE	3
`define WIN_PERM	3
`define WIN_FX1		1
`define WIN_BR		1

`define OP_ILA		7'b0100001	// RI18
`define OP_IL		9'b010000001	// RI16
`define OP_AI		8'b00011100	// RI10
`define OP_A		11'b00011000000
`define OP_AND		11'b00011000001
`define OP_OR		11'b00001000001
`define OP_XOR		11'b01001000001
`define OP_NOP		11'b01000000001
`define OP_SHL		11'b00001011011
`define OP_CNTB		11'b01010110100
`define OP_MPY		11'b01111000100
`define OP_FA		11'b01011000100
`define OP_LQD		8'b00110100	// RI10
`define OP_STQD		8'b00100100	// RI10
`define OP_LQX		11'b00111000100
`define OP_ROTQBY	11'b00111011100
`define OP_BR		9'b001100100	// RI16
`define OP_BRZ		9'b001000000	// RI16
`define OP_LNOP		11'b00000000001

`endif

//--- spu_decode_pkg.sv
`include "spu_decode_macros.svh"

package spu_decode_pkg;

	// FP, FX2, byte, FX1 on the even pipe; permute, load/store, branch on the odd pipe
	typedef logic [`UNIT_W-1:0] unit_t;

	typedef enum logic [1:0] {
		PIPE_NONE = 2'd0,
		PIPE_EVEN = 2'd1,
		PIPE_ODD  = 2'd2
	} pipe_t;

	typedef struct packed {
		logic [0:`INSTR_W-1]    word;
		logic [`OP_W-1:0]       op;	// right aligned, short opcodes zero padded
		logic [`FMT_W-1:0]      format;
		logic [`IMM_W-1:0]      imm;	// sign extended
		logic [`REG_ADDR_W-1:0] rt;
		logic [`REG_ADDR_W-1:0] ra;
		logic [`REG_ADDR_W-1:0] rb;
		logic [`REG_ADDR_W-1:0] rc;	// store data or branch condition
		logic                   ra_valid;
		logic                   rb_valid;
		logic                   rc_valid;
		logic                   write;	// rt gets written
		unit_t                  unit;
		pipe_t                  pipe;
	} decoded_t;

endpackage

//--- instr_classifier.sv
`timescale 1ns/10ps
`include "spu_decode_macros.svh"

module instr_classifier import spu_decode_pkg::*; (
	input  logic [0:`INSTR_W-1] instr,
	output decoded_t            dec
);

	localparam logic [`FMT_W-1:0] FMT_RR   = 3'd0;
	localparam logic [`FMT_W-1:0] FMT_RI10 = 3'd4;
	localparam logic [`FMT_W-1:0] FMT_RI16 = 3'd5;
	localparam logic [`FMT_W-1:0] FMT_RI18 = 3'd6;

	decoded_t            base;	// raw fields, before any table lookup
	decoded_t            even_dec;
	decoded_t            odd_dec;
	logic                even_hit;
	logic                odd_hit;
	logic [`IMM_W-1:0]   imm_ri10;
	logic [`IMM_W-1:0]   imm_ri16;
	logic [`IMM_W-1:0]   imm_ri18;

	assign imm_ri10 = {{8{instr[8]}}, instr[8:17]};
	assign imm_ri16 = {{2{instr[9]}}, instr[9:24]};
	assign imm_ri18 = instr[7:24];

	always_comb begin
		base       = '0;
		base.word  = instr;
		base.rt    = instr[25:31];
		base.ra    = instr[18:24];
		base.rb    = instr[11:17];
		base.rc    = instr[25:31];
		base.write = 1'b1;
	end

	// even table
	always_comb begin
		even_dec      = base;
		even_dec.pipe = PIPE_EVEN;
		even_hit      = 1'b1;
		if (instr[0:6] == `OP_ILA) begin
			even_dec.format = FMT_RI18;
			even_dec.op     = {{(`OP_W-7){1'b0}}, instr[0:6]};
			even_dec.imm    = imm_ri18;
			even_dec.unit   = `UNIT_FX1;
		end else if (instr[0:8] == `OP_IL) begin
			even_dec.format = FMT_RI16;
			even_dec.op     = {{(`OP_W-9){1'b0}}, instr[0:8]};
			even_dec.imm    = imm_ri16;
			even_dec.unit   = `UNIT_FX1;
		end else if (instr[0:7] == `OP_AI) begin
			even_dec.format   = FMT_RI10;
			even_dec.op       = {{(`OP_W-8){1'b0}}, instr[0:7]};
			even_dec.imm      = imm_ri10;
			even_dec.ra_valid = 1'b1;
			even_dec.unit     = `UNIT_FX1;
		end else begin
			even_dec.format   = FMT_RR;
			even_dec.op       = instr[0:10];
			even_dec.ra_valid = 1'b1;
			even_dec.rb_valid = 1'b1;
			case (instr[0:10])
				`OP_MPY, `OP_FA: even_dec.unit = `UNIT_FP;
				`OP_SHL: even_dec.unit = `UNIT_FX2;
				`OP_CNTB: begin
					even_dec.unit     = `UNIT_BYTE;
					even_dec.rb_valid = 1'b0;	// single source
				end
				`OP_A, `OP_AND, `OP_OR, `OP_XOR: even_dec.unit = `UNIT_FX1;
				`OP_NOP: begin
					even_dec.unit     = `UNIT_FP;
					even_dec.ra_valid = 1'b0;
					even_dec.rb_valid = 1'b0;
					even_dec.write    = 1'b0;
				end
				default: even_hit = 1'b0;
			endcase
		end
	end

	// odd table
	always_comb begin
		odd_dec      = base;
		odd_dec.pipe = PIPE_ODD;
		odd_hit      = 1'b1;
		if (instr[0:8] == `OP_BR || instr[0:8] == `OP_BRZ) begin
			odd_dec.format   = FMT_RI16;
			odd_dec.op       = {{(`OP_W-9){1'b0}}, instr[0:8]};
			odd_dec.imm      = imm_ri16;
			odd_dec.unit     = `UNIT_BR;
			odd_dec.write    = 1'b0;
			odd_dec.rc_valid = (instr[0:8] == `OP_BRZ);	// brz tests rt
		end else if (instr[0:7] == `OP_LQD || instr[0:7] == `OP_STQD) begin
			odd_dec.format   = FMT_RI10;
			odd_dec.op       = {{(`OP_W-8){1'b0}}, instr[0:7]};
			odd_dec.imm      = imm_ri10;
			odd_dec.unit     = `UNIT_LS;
			odd_dec.ra_valid = 1'b1;
			if (instr[0:7] == `OP_STQD) begin
				odd_dec.write    = 1'b0;
				odd_dec.rc_valid = 1'b1;	// store data comes from rt
			end
		end else begin
			odd_dec.format = FMT_RR;
			odd_dec.op     = instr[0:10];
			case (instr[0:10])
				`OP_LQX: begin
					odd_dec.unit     = `UNIT_LS;
					odd_dec.ra_valid = 1'b1;
					odd_dec.rb_valid = 1'b1;
				end
				`OP_ROTQBY: begin
					odd_dec.unit     = `UNIT_PERM;
					odd_dec.ra_valid = 1'b1;
					odd_dec.rb_valid = 1'b1;
				end
				`OP_LNOP: begin
					odd_dec.unit  = `UNIT_PERM;
					odd_dec.write = 1'b0;
				end
				default: odd_hit = 1'b0;
			endcase
		end
	end

	// even table wins, then odd, else nothing
	always_comb begin
		if (instr == '0 || !(even_hit || odd_hit)) begin
			dec      = '0;
			dec.word = instr;
			dec.pipe = PIPE_NONE;
		end else if (even_hit) begin
			dec = even_dec;
		end else begin
			dec = odd_dec;
		end
		assert (!(even_hit && odd_hit))
			else $error("opcode %b matches both pipe tables", instr[0:10]);
	end

endmodule

//--- dest_scoreboard.sv
`timescale 1ns/10ps
`include "spu_decode_macros.svh"

module dest_scoreboard import spu_decode_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   even_valid,
	input  logic                   even_write,
	input  unit_t                  even_unit,
	input  logic [`REG_ADDR_W-1:0] even_rt,
	input  logic                   odd_valid,
	input  logic                   odd_write,
	input  unit_t                  odd_unit,
	input  logic [`REG_ADDR_W-1:0] odd_rt,
	output logic [`NUM_REGS-1:0]   busy_mask
);

	localparam logic [`CNT_W-1:0] TICK = 'd1;

	logic [`CNT_W-1:0]    hold [`NUM_REGS];	// remaining busy cycles per register
	logic [`CNT_W-1:0]    even_hold;
	logic [`CNT_W-1:0]    odd_hold;
	logic [`NUM_REGS-1:0] even_sel;
	logic [`NUM_REGS-1:0] odd_sel;

	function automatic logic [`CNT_W-1:0] hold_cycles(input pipe_t pipe, input unit_t unit);
		int win;
		if (pipe == PIPE_EVEN) begin
			case (unit)
				`UNIT_FP:   win = `WIN_FP;
				`UNIT_FX2:  win = `WIN_FX2;
				`UNIT_BYTE: win = `WIN_BYTE;
				default:    win = `WIN_FX1;
			endcase
		end else begin
			case (unit)
				`UNIT_PERM: win = `WIN_PERM;
				`UNIT_LS:   win = `WIN_LS;
				default:    win = `WIN_BR;
			endcase
		end
		win = win - 1;	// the issue register cycle is the first one
		hold_cycles = win[`CNT_W-1:0];
	endfunction

	assign even_hold = hold_cycles(PIPE_EVEN, even_unit);
	assign odd_hold  = hold_cycles(PIPE_ODD, odd_unit);
	assign even_sel  = (even_valid && even_write) ?
		({{(`NUM_REGS-1){1'b0}}, 1'b1} << even_rt) : '0;
	assign odd_sel   = (odd_valid && odd_write) ?
		({{(`NUM_REGS-1){1'b0}}, 1'b1} << odd_rt) : '0;

	always_ff @(posedge clk) begin
		for (int r = 0; r < `NUM_REGS; r++) begin
			if (reset)
				hold[r] <= '0;
			else if (even_sel[r])
				hold[r] <= even_hold;
			else if (odd_sel[r])
				hold[r] <= odd_hold;
			else if (hold[r] != '0)
				hold[r] <= hold[r] - TICK;
		end
	end

	always_comb begin
		for (int r = 0; r < `NUM_REGS; r++) begin
			busy_mask[r] = (hold[r] != '0) || even_sel[r] || odd_sel[r];	// issue reg counts too
		end
	end

	// the WAW check upstream keeps the two pipes off the same target
	assert property (@(posedge clk) disable iff (reset) (even_sel & odd_sel) == '0);

endmodule

//--- issue_control.sv
`timescale 1ns/10ps
`include "spu_decode_macros.svh"

module issue_control import spu_decode_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [0:`INSTR_W-1]    instr_first,
	input  logic [0:`INSTR_W-1]    instr_second,
	input  logic [`PC_W-1:0]       pc,
	input  logic                   branch_taken,
	input  logic [`PC_W-1:0]       branch_target,
	input  logic [`NUM_REGS-1:0]   busy_mask,
	output logic                   even_valid,
	output logic [`OP_W-1:0]       even_op,
	output unit_t                  even_unit,
	output logic [`REG_ADDR_W-1:0] even_rt,
	output logic                   even_write,
	output logic [`IMM_W-1:0]      even_imm,
	output logic                   odd_valid,
	output logic [`OP_W-1:0]       odd_op,
	output unit_t                  odd_unit,
	output logic [`REG_ADDR_W-1:0] odd_rt,
	output logic                   odd_write,
	output logic [`IMM_W-1:0]      odd_imm,
	output logic                   first_odd,
	output logic                   stall,
	output logic [`PC_W-1:0]       stall_pc
);

	logic [0:`INSTR_W-1]  replay_first;	// held back words, program order
	logic [0:`INSTR_W-1]  replay_second;
	logic [0:`INSTR_W-1]  word_first;
	logic [0:`INSTR_W-1]  word_second;
	logic [`PC_W-1:0]     pair_pc;
	decoded_t             first;
	decoded_t             second;
	decoded_t             even_src;
	decoded_t             odd_src;
	logic [`NUM_REGS-1:0] first_wmask;
	logic                 structural;
	logic                 waw;
	logic                 block_first;
	logic                 block_second;
	logic                 first_go;
	logic                 second_go;
	logic                 even_from_first;
	logic                 odd_from_first;
	logic                 even_go;
	logic                 odd_go;
	logic                 ever_issued;

	function automatic logic reads_any(input decoded_t d, input logic [`NUM_REGS-1:0] mask);
		reads_any = (d.ra_valid && mask[d.ra]) ||
			(d.rb_valid && mask[d.rb]) ||
			(d.rc_valid && mask[d.rc]);
	endfunction

	// replay buffer takes over the decoders while stalled
	assign word_first  = stall ? replay_first : instr_first;
	assign word_second = stall ? replay_second : instr_second;
	assign pair_pc     = stall ? stall_pc : pc;

	instr_classifier cls_first (.instr(word_first), .dec(first));
	instr_classifier cls_second (.instr(word_second), .dec(second));

	assign first_wmask = first.write ? ({{(`NUM_REGS-1){1'b0}}, 1'b1} << first.rt) : '0;

	assign structural   = first.pipe != PIPE_NONE && first.pipe == second.pipe;
	assign waw          = first.write && second.write && first.rt == second.rt;
	assign block_first  = reads_any(first, busy_mask);
	assign block_second = structural || waw || reads_any(second, busy_mask | first_wmask);

	assign first_go  = !branch_taken && !block_first && first.pipe != PIPE_NONE;
	assign second_go = !branch_taken && !block_first && !block_second &&
		second.pipe != PIPE_NONE;

	assign even_from_first = first_go && first.pipe == PIPE_EVEN;
	assign odd_from_first  = first_go && first.pipe == PIPE_ODD;
	assign even_go  = even_from_first || (second_go && second.pipe == PIPE_EVEN);
	assign odd_go   = odd_from_first || (second_go && second.pipe == PIPE_ODD);
	assign even_src = even_from_first ? first : second;
	assign odd_src  = odd_from_first ? first : second;

	always_ff @(posedge clk) begin
		if (reset) begin
			even_valid  <= 1'b0;
			odd_valid   <= 1'b0;
			first_odd   <= 1'b0;
			stall       <= 1'b0;
			ever_issued <= 1'b0;
		end else begin
			even_valid  <= even_go;
			odd_valid   <= odd_go;
			first_odd   <= odd_from_first || (!first_go && odd_go);	// lone odd counts as first
			stall       <= branch_taken || block_first || block_second;
			ever_issued <= ever_issued || even_valid || odd_valid;
		end
	end

	always_ff @(posedge clk) begin
		even_op    <= even_src.op;
		even_unit  <= even_src.unit;
		even_rt    <= even_src.rt;
		even_write <= even_src.write;
		even_imm   <= even_src.imm;
		odd_op     <= odd_src.op;
		odd_unit   <= odd_src.unit;
		odd_rt     <= odd_src.rt;
		odd_write  <= odd_src.write;
		odd_imm    <= odd_src.imm;
		if (branch_taken) begin
			stall_pc      <= branch_target;	// flush, fetch restarts at target
			replay_first  <= '0;
			replay_second <= '0;
		end else if (block_first) begin
			stall_pc      <= pair_pc;
			replay_first  <= word_first;
			replay_second <= word_second;
		end else if (block_second) begin
			stall_pc      <= pair_pc;
			replay_first  <= word_second;	// moves up to the first slot
			replay_second <= '0;
		end
	end

	// hazards need something in flight, so only a branch can stall an idle stage
	assert property (@(posedge clk) disable iff (reset)
		!ever_issued && !even_valid && !odd_valid && !$past(branch_taken) |-> !stall);

	assert property (@(posedge clk) disable iff (reset)
		branch_taken |=> !even_valid && !odd_valid && stall);

endmodule

//--- spu_decode.sv
`timescale 1ns/10ps
`include "spu_decode_macros.svh"

module spu_decode import spu_decode_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [0:`INSTR_W-1]    instr_first,
	input  logic [0:`INSTR_W-1]    instr_second,
	input  logic [`PC_W-1:0]       pc,
	input  logic                   branch_taken,
	input  logic [`PC_W-1:0]       branch_target,
	output logic                   even_valid,
	output logic [`OP_W-1:0]       even_op,
	output unit_t                  even_unit,
	output logic [`REG_ADDR_W-1:0] even_rt,
	output logic                   even_write,
	output logic [`IMM_W-1:0]      even_imm,
	output logic                   odd_valid,
	output logic [`OP_W-1:0]       odd_op,
	output unit_t                  odd_unit,
	output logic [`REG_ADDR_W-1:0] odd_rt,
	output logic                   odd_write,
	output logic [`IMM_W-1:0]      odd_imm,
	output logic                   first_odd,
	output logic                   stall,
	output logic [`PC_W-1:0]       stall_pc
);

	logic [`NUM_REGS-1:0] busy_mask;	// in-flight destinations

	issue_control u_issue (
		.clk(clk), .reset(reset),
		.instr_first(instr_first), .instr_second(instr_second), .pc(pc),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.busy_mask(busy_mask),
		.even_valid(even_valid), .even_op(even_op), .even_unit(even_unit),
		.even_rt(even_rt), .even_write(even_write), .even_imm(even_imm),
		.odd_valid(odd_valid), .odd_op(odd_op), .odd_unit(odd_unit),
		.odd_rt(odd_rt), .odd_write(odd_write), .odd_imm(odd_imm),
		.first_odd(first_odd), .stall(stall), .stall_pc(stall_pc)
	);

	// fed from the registered issue outputs
	dest_scoreboard u_scoreboard (
		.clk(clk), .reset(reset),
		.even_valid(even_valid), .even_write(even_write),
		.even_unit(even_unit), .even_rt(even_rt),
		.odd_valid(odd_valid), .odd_write(odd_write),
		.odd_unit(odd_unit), .odd_rt(odd_rt),
		.busy_mask(busy_mask)
	);

endmodule

//--- tb_spu_decode.sv
`timescale 1ns/10ps
`include "spu_decode_macros.svh"

module tb_spu_decode import spu_decode_pkg::*; ();

	logic                   clk, reset, branch_taken;
	logic [31:0]            instr_first, instr_second;	// bit 31 is word bit 0
	logic [`PC_W-1:0]       pc, branch_target, stall_pc;
	logic                   even_valid, even_write, odd_valid, odd_write;
	logic [`OP_W-1:0]       even_op, odd_op;
	unit_t                  even_unit, odd_unit;
	logic [`REG_ADDR_W-1:0] even_rt, odd_rt;
	logic [`IMM_W-1:0]      even_imm, odd_imm;
	logic                   first_odd, stall;
	logic [`NUM_REGS-1:0]   used_regs;	// registers handed out in the current test
	int                     test_errors, error_total, tests_run, tests_failed;

	spu_decode dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] rr_word(input logic [10:0] op, input logic [6:0] rb,
		input logic [6:0] ra, input logic [6:0] rt);
		return {op, rb, ra, rt};
	endfunction

	function automatic logic [31:0] ri10_word(input logic [7:0] op, input logic [9:0] imm,
		input logic [6:0] ra, input logic [6:0] rt);
		return {op, imm, ra, rt};
	endfunction

	function automatic logic [`REG_ADDR_W-1:0] fresh_reg();
		int n;
		do begin
			n = $urandom_range(1, `NUM_REGS-1);
		end while (used_regs[n]);
		used_regs[n] = 1'b1;
		return n[`REG_ADDR_W-1:0];
	endfunction

	task automatic check(input logic ok, input string what);
		assert (ok) else begin
			$display("Error at %0d ns: %s", $time, what);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d check(s) failed", name, test_errors);
			tests_failed++;
		end
		error_total += test_errors;
		test_errors = 0;
		used_regs   = '0;
	endtask

	task automatic idle(input int cycles);
		instr_first  = '0;
		instr_second = '0;
		branch_taken = 1'b0;
		repeat (cycles) @(negedge clk);
	endtask

	// one pair for one cycle, returns with its issue outputs visible
	task automatic present(input logic [31:0] w1, input logic [31:0] w2,
		input logic [`PC_W-1:0] p);
		instr_first  = w1;
		instr_second = w2;
		pc           = p;
		@(negedge clk);
		instr_first  = '0;
		instr_second = '0;
	endtask

	task automatic wait_stall_low(input int limit);
		int n;
		n = 0;
		while (stall && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (stall) begin
			$display("timeout: stall still high after %0d cycles", limit);
			test_errors++;
		end
	endtask

	task automatic dual_issue(input logic odd_first);
		logic [`REG_ADDR_W-1:0] ai_rt, ai_ra, ld_rt, ld_ra;
		logic [31:0]            ai_w, ld_w;
		logic [9:0]             imm;
		int                     n;
		ai_rt = fresh_reg();
		ai_ra = fresh_reg();
		ld_rt = fresh_reg();
		ld_ra = fresh_reg();
		n     = $urandom;
		imm   = n[9:0];
		ai_w  = ri10_word(`OP_AI, imm, ai_ra, ai_rt);
		ld_w  = ri10_word(`OP_LQD, 10'd16, ld_ra, ld_rt);
		if (odd_first)
			present(ld_w, ai_w, 8'h20);
		else
			present(ai_w, ld_w, 8'h20);
		check(even_valid && odd_valid && !stall, "pair did not dual issue");
		check(even_op == {3'b000, `OP_AI}, "even_op is not ai");
		check(even_rt == ai_rt && even_unit == `UNIT_FX1 && even_write, "ai target or unit wrong");
		check($signed(even_imm) == $signed(imm), "ai immediate not sign extended");
		check(odd_op == {3'b000, `OP_LQD}, "odd_op is not lqd");
		check(odd_rt == ld_rt && odd_unit == `UNIT_LS && odd_write, "lqd target or unit wrong");
		check(odd_imm == 18'd16, "lqd offset wrong");
		check(first_odd == odd_first, "first_odd does not follow program order");
	endtask

	// second slot blocked on the pipe (a) or on the target (lqd onto the same rt)
	task automatic blocked_second(input logic same_target);
		logic [`REG_ADDR_W-1:0] r1, r2, r3, r4, r5;
		logic [`PC_W-1:0]       p;
		logic [31:0]            w2;
		int                     n;
		r1 = fresh_reg();
		r2 = fresh_reg();
		r3 = fresh_reg();
		r4 = fresh_reg();
		r5 = fresh_reg();
		n  = $urandom;
		p  = n[`PC_W-1:0];
		w2 = same_target ? ri10_word(`OP_LQD, 10'd0, r4, r1) : rr_word(`OP_A, r5, r4, r3);
		present(ri10_word(`OP_AI, 10'd3, r2, r1), w2, p);
		check(even_valid && even_op == {3'b000, `OP_AI} && even_rt == r1, "ai did not issue");
		check(!odd_valid, "second instruction issued with the first");
		check(stall && stall_pc == p, "no stall at the pair pc");
		wait_stall_low(10);
		if (same_target)
			check(odd_valid && !even_valid && odd_op == {3'b000, `OP_LQD} && odd_rt == r1,
				"lqd not replayed alone");
		else
			check(even_valid && !odd_valid && even_op == `OP_A && even_rt == r3,
				"a not replayed alone");
		idle(6);
	endtask

	task automatic read_after_write();
		logic [`REG_ADDR_W-1:0] r, x, y, t, la, lt, q, u;
		logic                   seen_stall;
		int                     n;
		r = fresh_reg();
		x = fresh_reg();
		y = fresh_reg();
		t = fresh_reg();
		la = fresh_reg();
		lt = fresh_reg();
		present(rr_word(`OP_FA, y, x, r), 32'd0, 8'h40);
		check(even_valid && even_unit == `UNIT_FP && even_rt == r, "fa did not issue");
		present(rr_word(`OP_A, y, r, t), ri10_word(`OP_LQD, 10'd0, la, lt), 8'h44);
		seen_stall = 1'b0;
		n = 0;
		while (!(even_valid && even_op == `OP_A) && n < 20) begin
			seen_stall = seen_stall || stall;
			@(negedge clk);
			n++;
		end
		if (!(even_valid && even_op == `OP_A)) begin
			$display("timeout: reader of r%0d never issued", r);
			test_errors++;
		end
		check(seen_stall, "no stall while the source was in flight");
		check(even_rt == t && odd_valid && odd_rt == lt, "reader pair issued wrongly");
		q = fresh_reg();
		u = fresh_reg();
		present(rr_word(`OP_A, q, q, u), 32'd0, 8'h48);	// q never written
		check(!stall && even_valid && even_rt == u, "stall on a register never written");
		idle(6);
	endtask

	task automatic branch_flush();
		logic [`REG_ADDR_W-1:0] r1, r2, r3, r4;
		logic [`PC_W-1:0]       target;
		logic                   leaked;
		int                     n;
		r1 = fresh_reg();
		r2 = fresh_reg();
		r3 = fresh_reg();
		r4 = fresh_reg();
		present(ri10_word(`OP_AI, 10'd1, r2, r1), rr_word(`OP_A, r4, r4, r3), 8'h60);
		check(stall, "a not queued behind ai");
		n             = $urandom;
		target        = n[`PC_W-1:0];
		branch_taken  = 1'b1;
		branch_target = target;
		@(negedge clk);
		branch_taken = 1'b0;
		check(!even_valid && !odd_valid, "valid high after a taken branch");
		check(stall && stall_pc == target, "no redirect to the branch target");
		leaked = 1'b0;
		repeat (8) begin
			@(negedge clk);
			leaked = leaked || even_valid || odd_valid;
		end
		check(!leaked, "flushed instruction issued after the branch");
		check(!stall, "stall still high after the flush");
	endtask

	task automatic unknown_word();
		logic [31:0] w;
		w = rr_word(11'h7ff, fresh_reg(), fresh_reg(), fresh_reg());
		present(w, w, 8'h70);
		check(!even_valid && !odd_valid, "unknown opcode issued");
		check(!stall, "unknown opcode caused a stall");
		idle(2);
	endtask

	initial begin
		void'($urandom(88725));
		reset         = 1'b1;
		instr_first   = '0;
		instr_second  = '0;
		pc            = '0;
		branch_taken  = 1'b0;
		branch_target = '0;
		used_regs     = '0;
		test_errors   = 0;
		error_total   = 0;
		tests_run     = 0;
		tests_failed  = 0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check(!even_valid && !odd_valid && !stall && !first_odd, "outputs high after reset");
		finish_test("reset state");
		dual_issue(1'b0);
		dual_issue(1'b1);
		finish_test("dual issue");
		idle(6);
		blocked_second(1'b0);
		blocked_second(1'b1);
		finish_test("structural and waw hazard");
		read_after_write();
		finish_test("read after write");
		branch_flush();
		finish_test("branch flush");
		unknown_word();
		finish_test("unknown word");
		$display("tests run %0d, failed %0d, failed checks %0d",
			tests_run, tests_failed, error_total);
		if (tests_failed == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- flist.f
+incdir+.
spu_decode_pkg.sv
instr_classifier.sv
dest_scoreboard.sv
issue_control.sv
spu_decode.sv
tb_spu_decode.sv

//--- Makefile
SIM = obj_dir/Vtb_spu_decode

all: run

$(SIM): *.sv *.svh flist.f
	verilator --binary --timing --assert --top-module tb_spu_decode -f flist.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -qF '*** FAILED ***' sim.log

lint:
	verilator --lint-only -Wall --timing --top-module spu_decode -f flist.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
